// File: Makefile
VERILATOR ?= verilator
TOP       := cpuTb
FILELIST  := compile.f
OBJDIR    := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal -Mdir $(OBJDIR)

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// File: compile.f
+incdir+include
hw/cpuPkg.sv
hw/wordRam.sv
hw/aluUnit.sv
hw/cpuCore.sv
hw/apbHostPort.sv
hw/cpuTop.sv
dv/cpuTb.sv

// File: dv/cpuTb.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpuSettings_settings.svh"

module cpuTb
	import cpuPkg::*;
();

	localparam int numProgs = 6;
	localparam int maxWords = 20;
	localparam int apbTimeout = 20;
	localparam int pollLimit = 200;

	logic clk;
	logic rst;
	apbReqT req;
	apbRspT rsp;
	logic [31:0] lfsr;

	instrT progTable [numProgs][maxWords];
	int progLen [numProgs];
	archStateT expTable [numProgs];

	cpuTop u_dut (
		.clk(clk),
		.rst(rst),
		.apbReq(req),
		.apbRsp(rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ####################################################################
	// Error handling and compares
	// ####################################################################

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		abortRun($sformatf("FAILED %s got 0x%0h expected 0x%0h", what, got, exp));
	endtask

	task automatic checkArch(input string what, input archStateT got, input archStateT exp);
		if (got.a !== exp.a)
			reportMismatch({what, ".a"}, 32'(got.a), 32'(exp.a));
		if (got.b !== exp.b)
			reportMismatch({what, ".b"}, 32'(got.b), 32'(exp.b));
		if (got.flags.z !== exp.flags.z)
			reportMismatch({what, ".flags.z"}, 32'(got.flags.z), 32'(exp.flags.z));
		if (got.flags.c !== exp.flags.c)
			reportMismatch({what, ".flags.c"}, 32'(got.flags.c), 32'(exp.flags.c));
		if (got.pc !== exp.pc)
			reportMismatch({what, ".pc"}, 32'(got.pc), 32'(exp.pc));
	endtask

	task automatic checkResp(input string what, input logic got, input logic exp);
		if (got !== exp)
			reportMismatch({what, ".pslverr"}, 32'(got), 32'(exp));
	endtask

	// ####################################################################
	// APB access
	// ####################################################################

	task automatic apbTransfer(input logic write, input logic [12:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waitCount;
		@(negedge clk);
		req.psel = 1'b1;
		req.penable = 1'b0;
		req.pwrite = write;
		req.paddr = addr;
		req.pwdata = wdata;
		@(negedge clk);
		req.penable = 1'b1;
		for (waitCount = 0; waitCount < apbTimeout; waitCount++)
		begin
			@(negedge clk);
			if (rsp.pready)
				break;
		end
		if (!rsp.pready)
			abortRun($sformatf("APB transfer to 0x%0h never saw pready", addr));
		rdata = rsp.prdata;
		err = rsp.pslverr;
		req.psel = 1'b0;
		req.penable = 1'b0;
	endtask

	task automatic apbWrite(input logic [12:0] addr, input logic [31:0] data,
		input logic expErr, input string what);
		logic [31:0] unused;
		logic err;
		apbTransfer(1'b1, addr, data, unused, err);
		checkResp(what, err, expErr);
	endtask

	task automatic apbRead(input logic [12:0] addr, input logic expErr,
		input string what, output logic [31:0] data);
		logic err;
		apbTransfer(1'b0, addr, '0, data, err);
		checkResp(what, err, expErr);
	endtask

	// ####################################################################
	// Stimulus table
	// ####################################################################

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		// Taps 32, 22, 2, 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic byteT randomByte();
		byteT r;
		r = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrStep(lfsr);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic instrT encode(input opcodeT op, input logic [9:0] arg);
		instrT w;
		w.opcode = op;
		w.arg.addr = arg;
		return w;
	endfunction

	task automatic pushWord(input int p, input opcodeT op, input logic [9:0] arg);
		progTable[p][progLen[p]] = encode(op, arg);
		progLen[p]++;
	endtask

	task automatic setExp(input int p, input byteT a, input byteT b, input logic z,
		input logic c, input logic [9:0] pc);
		expTable[p].a = a;
		expTable[p].b = b;
		expTable[p].flags.z = z;
		expTable[p].flags.c = c;
		expTable[p].pc = pc;
	endtask

	task automatic buildTable();
		byteT x;
		byteT y;
		for (int p = 0; p < numProgs; p++)
			progLen[p] = 0;

		// Immediate loads and swap
		pushWord(0, OP_LDAI, 10'h03c);
		pushWord(0, OP_LDBI, 10'h0a5);
		pushWord(0, OP_SWAP, 10'd0);
		pushWord(0, OP_JMP, 10'd3);
		setExp(0, 8'ha5, 8'h3c, 1'b0, 1'b0, 10'd3);

		// ADD sets C when the true sum does not fit in a byte
		x = randomByte();
		y = randomByte();
		pushWord(1, OP_LDAI, 10'(x));
		pushWord(1, OP_LDBI, 10'(y));
		pushWord(1, OP_ADD, 10'd0);
		pushWord(1, OP_JMP, 10'd3);
		setExp(1, byteT'(x + y), y, byteT'(x + y) == 8'h00, int'(x) + int'(y) > 255, 10'd3);

		// SUB sets C when B exceeds A
		x = randomByte();
		y = randomByte();
		pushWord(2, OP_LDAI, 10'(x));
		pushWord(2, OP_LDBI, 10'(y));
		pushWord(2, OP_SUB, 10'd0);
		pushWord(2, OP_JMP, 10'd3);
		setExp(2, byteT'(x - y), y, x == y, y > x, 10'd3);

		// F0 + 20 carries, then the logic ops must keep C
		pushWord(3, OP_LDAI, 10'h0f0);
		pushWord(3, OP_LDBI, 10'h020);
		pushWord(3, OP_ADD, 10'd0);
		pushWord(3, OP_LDBI, 10'h00f);
		pushWord(3, OP_OR, 10'd0);
		pushWord(3, OP_NOT, 10'd0);
		pushWord(3, OP_AND, 10'd0);
		pushWord(3, OP_JMP, 10'd7);
		setExp(3, 8'h00, 8'h0f, 1'b1, 1'b1, 10'd7);

		pushWord(4, OP_LDAI, 10'h05a);
		pushWord(4, OP_STA, 10'd9);
		pushWord(4, OP_LDAI, 10'h000);
		pushWord(4, OP_LDA, 10'd9);
		pushWord(4, OP_JMP, 10'd4);
		setExp(4, 8'h5a, 8'h00, 1'b0, 1'b0, 10'd4);

		// Every wrong branch lands on the trap at 17, which loads EE into B
		pushWord(5, OP_LDAI, 10'h001);
		pushWord(5, OP_LDBI, 10'h001);
		pushWord(5, OP_SUB, 10'd0);
		pushWord(5, OP_JZ, 10'd5);
		pushWord(5, OP_JMP, 10'd17);
		pushWord(5, OP_JNC, 10'd7);
		pushWord(5, OP_JMP, 10'd17);
		pushWord(5, OP_JNZ, 10'd17);
		pushWord(5, OP_JC, 10'd17);
		pushWord(5, OP_SUB, 10'd0);
		pushWord(5, OP_JC, 10'd12);
		pushWord(5, OP_JMP, 10'd17);
		pushWord(5, OP_JNZ, 10'd14);
		pushWord(5, OP_JMP, 10'd17);
		pushWord(5, OP_JZ, 10'd17);
		pushWord(5, OP_JNC, 10'd17);
		pushWord(5, OP_JMP, 10'd18);
		pushWord(5, OP_LDBI, 10'h0ee);
		pushWord(5, OP_JMP, 10'd18);
		setExp(5, 8'hff, 8'h01, 1'b0, 1'b1, 10'd18);
	endtask

	// ####################################################################
	// Program runs
	// ####################################################################

	task automatic runProgram(input int p, input logic load);
		logic [31:0] data;
		archStateT got;
		int polls;
		string tag;
		tag = $sformatf("prog%0d", p);
		apbWrite(`CPU_ADDR_CTRL, 32'd0, 1'b0, {tag, ".stop"});
		if (load)
		begin
			for (int i = 0; i < progLen[p]; i++)
				apbWrite(13'(i * 4), {18'd0, progTable[p][i]}, 1'b0, {tag, ".load"});
		end
		apbWrite(`CPU_ADDR_CTRL, 32'd1, 1'b0, {tag, ".start"});

		// The halt loop jumps to itself, so the PC settles there
		data = '0;
		for (polls = 0; polls < pollLimit; polls++)
		begin
			apbRead(`CPU_ADDR_PC, 1'b0, {tag, ".pcRead"}, data);
			if (data[9:0] == expTable[p].pc)
				break;
		end
		if (data[9:0] != expTable[p].pc)
			abortRun($sformatf("%s never reached its halt address 0x%0h", tag,
				expTable[p].pc));
		got.pc = data[9:0];
		apbRead(`CPU_ADDR_REGS, 1'b0, {tag, ".regsRead"}, data);
		got.a = data[7:0];
		got.b = data[15:8];
		got.flags.z = data[16];
		got.flags.c = data[17];
		checkArch(tag, got, expTable[p]);
	endtask

	task automatic checkBusErrors();
		logic [31:0] data;
		// The last program is still running at its halt loop
		apbWrite(13'h0000, {18'd0, encode(OP_LDAI, 10'h077)}, 1'b1, "writeWhileRunning");
		apbRead(13'h0004, 1'b1, "programWindowRead", data);
		apbRead(13'h100c, 1'b1, "unmappedRead", data);
		apbWrite(13'h1010, 32'd1, 1'b1, "unmappedWrite");
		apbWrite(`CPU_ADDR_PC, 32'd0, 1'b1, "pcWrite");
	endtask

	initial
	begin
		rst = 1'b0;
		req = '0;
		lfsr = 32'h107e_479d;
		buildTable();
		repeat (10) @(negedge clk);
		rst = 1'b1;

		for (int p = 0; p < numProgs; p++)
			runProgram(p, 1'b1);

		checkBusErrors();
		// Same program again without reloading, so word 0 must be intact
		runProgram(numProgs - 1, 1'b0);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/aluUnit.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpuSettings_settings.svh"

module aluUnit
	import cpuPkg::*;
(
	input wire opcodeT op,
	input wire byteT a,
	input wire byteT b,
	input wire flagsT flagsIn,
	output byteT result,
	output flagsT flagsOut
);

	logic [`CPU_DATA_W:0] sum;
	logic [`CPU_DATA_W:0] diff;
	logic aluOp;

	// The ninth bit is the carry out of ADD and the borrow of SUB
	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb
	begin
		result = a;
		flagsOut = flagsIn;
		aluOp = 1'b1;
		case (op)
			OP_AND:
			begin
				result = a & b;
			end
			OP_OR:
			begin
				result = a | b;
			end
			OP_NOT:
			begin
				result = ~a;
			end
			OP_ADD:
			begin
				result = sum[`CPU_DATA_W-1:0];
				flagsOut.c = sum[`CPU_DATA_W];
			end
			OP_SUB:
			begin
				result = diff[`CPU_DATA_W-1:0];
				flagsOut.c = diff[`CPU_DATA_W];
			end
			default:
			begin
				aluOp = 1'b0;
			end
		endcase

		// Logic ops keep the incoming carry, all five set Z from the result
		if (aluOp)
		begin
			flagsOut.z = (result == '0);
		end
	end

endmodule

`default_nettype wire

// File: hw/apbHostPort.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpuSettings_settings.svh"

module apbHostPort
	import cpuPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire apbReqT apbReq,
	output apbRspT apbRsp,
	output progWrT progWr,
	output logic run,
	input wire archStateT state
);

	logic access;
	logic inWindow;
	logic isCtrl;
	logic isPc;
	logic isRegs;
	logic err;
	logic [`CPU_APB_DATA_W-1:0] readData;
	logic rspReady;
	logic rspErr;
	logic [`CPU_APB_DATA_W-1:0] rspData;
	logic wrEnQ;
	logic [`CPU_PC_W-1:0] wrAddrQ;
	instrT wrDataQ;

	// First access cycle, before the wait state has passed
	assign access = apbReq.psel & apbReq.penable & ~rspReady;

	assign inWindow = apbReq.paddr >= `CPU_PROG_WIN_LO && apbReq.paddr <= `CPU_PROG_WIN_HI;
	assign isCtrl = apbReq.paddr == `CPU_ADDR_CTRL;
	assign isPc = apbReq.paddr == `CPU_ADDR_PC;
	assign isRegs = apbReq.paddr == `CPU_ADDR_REGS;

	always_comb
	begin
		readData = '0;
		err = 1'b0;
		if (apbReq.pwrite)
		begin
			// PC and register readback are read only
			err = (inWindow & run) | ~(inWindow | isCtrl);
		end
		else if (isCtrl)
			readData[`CPU_CTRL_RUN_BIT] = run;
		else if (isPc)
			readData[`CPU_PC_W-1:0] = state.pc;
		else if (isRegs)
			readData[17:0] = {state.flags.c, state.flags.z, state.b, state.a};
		else
			err = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			rspReady <= 1'b0;
			rspErr <= 1'b0;
			wrEnQ <= 1'b0;
			run <= 1'b0;
		end
		else
		begin
			rspReady <= access;
			rspErr <= access & err;
			wrEnQ <= access & apbReq.pwrite & inWindow & ~run;
			if (access && apbReq.pwrite && isCtrl)
			begin
				run <= apbReq.pwdata[`CPU_CTRL_RUN_BIT];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (access)
		begin
			rspData <= readData;
			wrAddrQ <= apbReq.paddr[`CPU_PROG_IDX_MSB:`CPU_PROG_IDX_LSB];
			wrDataQ <= instrT'(apbReq.pwdata[$bits(instrT)-1:0]);
		end
	end

	assign apbRsp = '{pready: rspReady, prdata: rspData, pslverr: rspErr};
	assign progWr = '{en: wrEnQ, addr: wrAddrQ, data: wrDataQ};

	apbStable: assert property (
		@(posedge clk) disable iff (!rst)
		apbReq.psel && apbReq.penable |-> $stable(apbReq.paddr) && $stable(apbReq.pwrite)
	)
		else $error("APB address or direction changed before pready");

endmodule

`default_nettype wire

// File: hw/cpuCore.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpuSettings_settings.svh"

module cpuCore
	import cpuPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	output logic [`CPU_PC_W-1:0] progAddr,
	input wire instrT instr,
	output archStateT state
);

	localparam int dataAddrW = $clog2(`CPU_DATA_DEPTH);

	phaseT phase;
	logic runQ;
	logic start;
	logic stepEn;
	logic [`CPU_PC_W-1:0] pc;
	byteT regA;
	byteT regB;
	flagsT flags;
	byteT aluResult;
	flagsT aluFlags;
	logic taken;
	logic dataWrEn;
	logic [dataAddrW-1:0] dataAddr;
	byteT dataRd;

	// A rising run level restarts the program, the cycle after it steps
	assign start = run & ~runQ;
	assign stepEn = run & runQ;

	assign progAddr = pc;
	assign dataAddr = instr.arg.addr[dataAddrW-1:0];
	assign dataWrEn = stepEn && phase == PH_EXEC && instr.opcode == OP_STA;
	assign state = '{a: regA, b: regB, flags: flags, pc: pc};

	always_comb
	begin
		case (instr.opcode)
			OP_JMP: taken = 1'b1;
			OP_JZ: taken = flags.z;
			OP_JC: taken = flags.c;
			OP_JNZ: taken = ~flags.z;
			OP_JNC: taken = ~flags.c;
			default: taken = 1'b0;
		endcase
	end

	aluUnit alu (
		.op(instr.opcode),
		.a(regA),
		.b(regB),
		.flagsIn(flags),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	wordRam #(
		.wordT(byteT),
		.depth(`CPU_DATA_DEPTH)
	) dataMem (
		.clk(clk),
		.wrEn(dataWrEn),
		.wrAddr(dataAddr),
		.wrData(regA),
		.rdAddr(dataAddr),
		.rdData(dataRd)
	);

	// ####################################################################
	// Fetch and execute sequencer
	// ####################################################################

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			runQ <= 1'b0;
			phase <= PH_FETCH;
			pc <= '0;
			regA <= '0;
			regB <= '0;
			flags <= '0;
		end
		else
		begin
			runQ <= run;
			if (start)
			begin
				phase <= PH_FETCH;
				pc <= '0;
				regA <= '0;
				regB <= '0;
				flags <= '0;
			end
			else if (stepEn)
			begin
				case (phase)
					PH_FETCH:
						phase <= PH_EXEC;
					PH_EXEC:
					begin
						phase <= (instr.opcode == OP_LDA) ? PH_LOAD : PH_FETCH;
						pc <= taken ? instr.arg.addr : pc + 1'b1;
						case (instr.opcode)
							OP_LDAI: regA <= instr.arg.lit.imm;
							OP_LDBI: regB <= instr.arg.lit.imm;
							OP_SWAP:
							begin
								regA <= regB;
								regB <= regA;
							end
							OP_AND, OP_OR, OP_NOT, OP_ADD, OP_SUB:
							begin
								regA <= aluResult;
								flags <= aluFlags;
							end
							default: ;
						endcase
					end
					PH_LOAD:
					begin
						regA <= dataRd;
						phase <= PH_FETCH;
					end
					default:
						phase <= PH_FETCH;
				endcase
			end
		end
	end

	phaseLegal: assert property (
		@(posedge clk) disable iff (!rst) phase inside {PH_FETCH, PH_EXEC, PH_LOAD}
	)
		else $error("core left its legal phases");

	noWriteHalted: assert property (
		@(posedge clk) disable iff (!rst) !run |-> !dataWrEn
	)
		else $error("data memory write while halted");

endmodule

`default_nettype wire

// File: hw/cpuPkg.sv
`default_nettype none
`include "cpuSettings_settings.svh"

package cpuPkg;

	// ####################################################################
	// Instruction set
	// ####################################################################

	typedef enum logic [3:0] {
		OP_NOP  = 4'b0000,
		OP_LDBI = 4'b0001,
		OP_LDA  = 4'b0010,
		OP_STA  = 4'b0011,
		OP_SWAP = 4'b0100,
		OP_JMP  = 4'b0101,
		OP_JZ   = 4'b0110,
		OP_JC   = 4'b0111,
		OP_JNZ  = 4'b1000,
		OP_JNC  = 4'b1001,
		OP_LDAI = 4'b1010,
		OP_AND  = 4'b1011,
		OP_OR   = 4'b1100,
		OP_NOT  = 4'b1101,
		OP_ADD  = 4'b1110,
		OP_SUB  = 4'b1111
	} opcodeT;

	typedef logic [`CPU_DATA_W-1:0] byteT;

	// The immediate shares the low bits of the address field
	typedef union packed {
		logic [`CPU_PC_W-1:0] addr;
		struct packed {
			logic [`CPU_PC_W-`CPU_DATA_W-1:0] pad;
			byteT imm;
		} lit;
	} operandT;

	typedef struct packed {
		opcodeT opcode;
		operandT arg;
	} instrT;

	// ####################################################################
	// Core state
	// ####################################################################

	typedef struct packed {
		logic z;
		logic c;
	} flagsT;

	typedef struct packed {
		byteT a;
		byteT b;
		flagsT flags;
		logic [`CPU_PC_W-1:0] pc;
	} archStateT;

	typedef enum logic [1:0] {
		PH_FETCH = 2'd0,
		PH_EXEC  = 2'd1,
		PH_LOAD  = 2'd2
	} phaseT;

	// ####################################################################
	// Host side
	// ####################################################################

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`CPU_APB_ADDR_W-1:0] paddr;
		logic [`CPU_APB_DATA_W-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic pready;
		logic [`CPU_APB_DATA_W-1:0] prdata;
		logic pslverr;
	} apbRspT;

	typedef struct packed {
		logic en;
		logic [`CPU_PC_W-1:0] addr;
		instrT data;
	} progWrT;

endpackage

`default_nettype wire

// File: hw/cpuTop.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpuSettings_settings.svh"

module cpuTop
	import cpuPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire apbReqT apbReq,
	output apbRspT apbRsp
);

	progWrT progWr;
	logic run;
	archStateT archState;
	logic [`CPU_PC_W-1:0] progAddr;
	instrT instr;

	apbHostPort hostPort (
		.clk(clk),
		.rst(rst),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.progWr(progWr),
		.run(run),
		.state(archState)
	);

	// Written by the host while halted, read by the core on fetch
	wordRam #(
		.wordT(instrT),
		.depth(`CPU_PROG_DEPTH)
	) progMem (
		.clk(clk),
		.wrEn(progWr.en),
		.wrAddr(progWr.addr),
		.wrData(progWr.data),
		.rdAddr(progAddr),
		.rdData(instr)
	);

	cpuCore core (
		.clk(clk),
		.rst(rst),
		.run(run),
		.progAddr(progAddr),
		.instr(instr),
		.state(archState)
	);

endmodule

`default_nettype wire

// File: hw/wordRam.sv
`default_nettype none
`timescale 1ns/1ps

module wordRam #(
	parameter type wordT = logic [7:0],
	parameter int depth = 16,
	localparam int addrW = $clog2(depth)
)(
	input wire logic clk,
	input wire logic wrEn,
	input wire logic [addrW-1:0] wrAddr,
	input wire wordT wrData,
	input wire logic [addrW-1:0] rdAddr,
	output wordT rdData
);

	wordT mem [depth];

	// Read data appears one cycle after the address
	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
		rdData <= mem[rdAddr];
	end

	wrAddrInRange: assert property (
		@(posedge clk) wrEn |-> 32'(wrAddr) < depth
	)
		else $error("wordRam write to address %0d beyond depth %0d", wrAddr, depth);

endmodule

`default_nettype wire

// File: include/cpuSettings_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Memory sizes in words
`define CPU_PROG_DEPTH 1024
`define CPU_DATA_DEPTH 16

// Word widths
`define CPU_DATA_W 8
`define CPU_PC_W 10
`define CPU_APB_ADDR_W 13
`define CPU_APB_DATA_W 32

// APB register map
`define CPU_ADDR_CTRL 13'h1000
`define CPU_ADDR_PC 13'h1004
`define CPU_ADDR_REGS 13'h1008
`define CPU_CTRL_RUN_BIT 0

// Program window, one instruction per 32-bit word
`define CPU_PROG_WIN_LO 13'h0000
`define CPU_PROG_WIN_HI 13'h0FFC
`define CPU_PROG_IDX_MSB 11
`define CPU_PROG_IDX_LSB 2

`endif
